// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = cpu_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/cpu_params.svh ====
/*
 * CPU subsystem parameters
 * RAM size, reset vector and the opcode bytes of the supported 6502 subset
 */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define RAM_ADDR_BITS 8
`define RESET_PC      16'h0000

`define OP_LDA_IMM 8'hA9
`define OP_LDA_ABS 8'hAD
`define OP_STA_ABS 8'h8D
`define OP_ADC_IMM 8'h69
`define OP_AND_IMM 8'h29
`define OP_ORA_IMM 8'h09
`define OP_EOR_IMM 8'h49
`define OP_TAX     8'hAA
`define OP_INX     8'hE8
`define OP_JMP_ABS 8'h4C
`define OP_NOP     8'hEA
`define OP_BRK     8'h00

`endif

// ==== logic/control.sv ====
/*
 * Control unit
 * FSM plus opcode decode ROM, drives the datapath strobes and the memory request
 */
`timescale 1ns/1ps
`include "cpu_params.svh"

module control import cpu_pkg::*; (
  input  logic    ph1,
  input  logic    rst_n,
  input  logic    run,
  input  data_t   ir,
  input  logic    cpu_gnt,
  output logic    halt,
  output logic    ir_load,
  output logic    a_load,
  output logic    x_load,
  output logic    flags_load,
  output logic    pc_inc,
  output logic    pc_load,
  output logic    tl_load,
  output logic    th_load,
  output logic    addr_sel,
  output logic    src_sel,
  output logic    mem_req,
  output logic    mem_we,
  output alu_op_t alu_op
);

  typedef enum logic [3:0] {
    idle, fetch, decode, operand_lo, operand_hi, mem_read, mem_write, execute, halted
  } state_t;

  typedef enum logic [2:0] {
    cls_imm, cls_impl, cls_lda_abs, cls_sta_abs, cls_jmp, cls_brk
  } cls_t;

  typedef enum logic [1:0] {dst_none, dst_a, dst_x} dst_t;

  state_t  state, next_state;
  cls_t    cls;
  dst_t    dst;
  alu_op_t rom_op;
  logic    stall_q;
  logic    fresh;

  // opcode ROM: class, ALU operation and destination
  always_comb begin
    cls    = cls_impl;
    rom_op = pass_b;
    dst    = dst_none;
    case (ir)
      `OP_LDA_IMM: begin cls = cls_imm; dst = dst_a; end
      `OP_LDA_ABS: begin cls = cls_lda_abs; dst = dst_a; end
      `OP_STA_ABS: cls = cls_sta_abs;
      `OP_ADC_IMM: begin cls = cls_imm; rom_op = add_c; dst = dst_a; end
      `OP_AND_IMM: begin cls = cls_imm; rom_op = and_op; dst = dst_a; end
      `OP_ORA_IMM: begin cls = cls_imm; rom_op = or_op; dst = dst_a; end
      `OP_EOR_IMM: begin cls = cls_imm; rom_op = eor_op; dst = dst_a; end
      `OP_TAX:     dst = dst_x;
      `OP_INX:     begin rom_op = inc; dst = dst_x; end
      `OP_JMP_ABS: cls = cls_jmp;
      `OP_NOP:     cls = cls_impl;
      `OP_BRK:     cls = cls_brk;
      // unknown opcodes run as NOP
      default:     cls = cls_impl;
    endcase
  end

  assign alu_op  = rom_op;
  assign src_sel = (rom_op == inc);
  assign halt    = (state == halted);

  // rdata holds this state's byte only on the first cycle after a granted read
  assign fresh = ~stall_q;

  always_comb begin
    next_state = state;
    ir_load    = 1'b0;
    a_load     = 1'b0;
    x_load     = 1'b0;
    flags_load = 1'b0;
    pc_inc     = 1'b0;
    pc_load    = 1'b0;
    tl_load    = 1'b0;
    th_load    = 1'b0;
    addr_sel   = 1'b0;
    mem_req    = 1'b0;
    mem_we     = 1'b0;
    case (state)
      idle: if (run) next_state = fetch;
      fetch: begin
        mem_req = 1'b1;
        if (cpu_gnt) begin
          pc_inc     = 1'b1;
          next_state = decode;
        end
      end
      decode: begin
        ir_load = fresh;
        case (cls)
          cls_brk:  next_state = halted;
          cls_impl: next_state = execute;
          default: begin
            // operand byte follows the opcode
            mem_req = 1'b1;
            if (cpu_gnt) begin
              pc_inc     = 1'b1;
              next_state = (cls == cls_imm) ? execute : operand_lo;
            end
          end
        endcase
      end
      operand_lo: begin
        tl_load = fresh;
        mem_req = 1'b1;
        if (cpu_gnt) begin
          pc_inc     = 1'b1;
          next_state = (cls == cls_lda_abs) ? mem_read : operand_hi;
        end
      end
      operand_hi: begin
        th_load    = 1'b1;
        next_state = (cls == cls_jmp) ? execute : mem_write;
      end
      mem_read: begin
        // high address byte goes straight to the bus on the first cycle
        th_load  = fresh;
        addr_sel = 1'b1;
        mem_req  = 1'b1;
        if (cpu_gnt) next_state = execute;
      end
      mem_write: begin
        addr_sel = 1'b1;
        mem_req  = 1'b1;
        mem_we   = 1'b1;
        if (cpu_gnt) next_state = fetch;
      end
      execute: begin
        case (dst)
          dst_a: begin a_load = 1'b1; flags_load = 1'b1; end
          dst_x: begin x_load = 1'b1; flags_load = 1'b1; end
          default: ;
        endcase
        pc_load    = (cls == cls_jmp);
        next_state = fetch;
      end
      halted: next_state = halted;
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge ph1 or negedge rst_n) begin
    if (!rst_n) begin
      state   <= idle;
      stall_q <= 1'b0;
    end else begin
      state   <= next_state;
      stall_q <= mem_req & ~cpu_gnt;
    end
  end

endmodule

// ==== logic/cpu_pkg.sv ====
/*
 * Shared types of the CPU subsystem
 * data and address vectors, RAM index and ALU operation codes
 */
`include "cpu_params.svh"

package cpu_pkg;

  // one byte on the data bus
  typedef logic [7:0] data_t;

  // full CPU address, TH:TL or PC
  typedef logic [15:0] addr_t;

  // index into the RAM, CPU address is taken modulo the RAM size
  typedef logic [`RAM_ADDR_BITS-1:0] ram_addr_t;

  typedef enum logic [2:0] {
    pass_b,
    add_c,
    and_op,
    or_op,
    eor_op,
    inc
  } alu_op_t;

endpackage

// ==== logic/cpu_top.sv ====
/*
 * CPU subsystem top
 * control, datapath, arbiter and RAM with an external host port
 */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
  input  logic      ph1,
  input  logic      rst_n,
  input  logic      run,
  input  logic      host_req,
  input  logic      host_we,
  input  ram_addr_t host_addr,
  input  data_t     host_wdata,
  output data_t     host_rdata,
  output logic      halt
);

  logic      ir_load, a_load, x_load, flags_load;
  logic      pc_inc, pc_load, tl_load, th_load;
  logic      addr_sel, src_sel;
  logic      mem_req, mem_we, cpu_gnt;
  alu_op_t   alu_op;
  data_t     ir;
  addr_t     cpu_addr;
  data_t     cpu_wdata;
  logic      ram_we;
  ram_addr_t ram_addr;
  data_t     ram_wdata;
  data_t     rdata;

  assign host_rdata = rdata;

  control ctrl0 (
    .ph1(ph1), .rst_n(rst_n), .run(run), .ir(ir), .cpu_gnt(cpu_gnt), .halt(halt),
    .ir_load(ir_load), .a_load(a_load), .x_load(x_load), .flags_load(flags_load),
    .pc_inc(pc_inc), .pc_load(pc_load), .tl_load(tl_load), .th_load(th_load),
    .addr_sel(addr_sel), .src_sel(src_sel), .mem_req(mem_req), .mem_we(mem_we),
    .alu_op(alu_op)
  );

  datapath dp0 (
    .ph1(ph1), .rst_n(rst_n),
    .ir_load(ir_load), .a_load(a_load), .x_load(x_load), .flags_load(flags_load),
    .pc_inc(pc_inc), .pc_load(pc_load), .tl_load(tl_load), .th_load(th_load),
    .addr_sel(addr_sel), .src_sel(src_sel), .alu_op(alu_op), .rdata(rdata),
    .ir(ir), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata)
  );

  mem_arbiter arb0 (
    .ph1(ph1), .rst_n(rst_n),
    .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
    .host_wdata(host_wdata), .mem_req(mem_req), .mem_we(mem_we),
    .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_gnt(cpu_gnt),
    .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata)
  );

  ram ram0 (
    .ph1(ph1), .ram_we(ram_we), .ram_addr(ram_addr),
    .ram_wdata(ram_wdata), .rdata(rdata)
  );

endmodule

// ==== logic/datapath.sv ====
/*
 * CPU datapath
 * A, X, IR, C/Z/N flags, PC, TH/TL temp address, ALU and bus muxing
 */
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath import cpu_pkg::*; (
  input  logic    ph1,
  input  logic    rst_n,
  input  logic    ir_load,
  input  logic    a_load,
  input  logic    x_load,
  input  logic    flags_load,
  input  logic    pc_inc,
  input  logic    pc_load,
  input  logic    tl_load,
  input  logic    th_load,
  input  logic    addr_sel,
  input  logic    src_sel,
  input  alu_op_t alu_op,
  input  data_t   rdata,
  output data_t   ir,
  output addr_t   cpu_addr,
  output data_t   cpu_wdata
);

  data_t      ir_q;
  data_t      a_q;
  data_t      x_q;
  data_t      tl_q;
  data_t      th_q;
  addr_t      pc_q;
  logic       c_q, z_q, n_q;
  data_t      th_cur;
  data_t      alu_b;
  data_t      alu_y;
  data_t      x_d;
  data_t      wb;
  logic [8:0] sum;
  logic       alu_c;

  // opcode is visible to the decoder in the cycle it is loaded
  assign ir     = ir_load ? rdata : ir_q;
  assign th_cur = th_load ? rdata : th_q;

  assign cpu_addr  = addr_sel ? {th_cur, tl_q} : pc_q;
  assign cpu_wdata = a_q;

  assign alu_b = src_sel ? x_q : rdata;
  assign sum   = {1'b0, a_q} + {1'b0, alu_b} + {8'd0, c_q};

  always_comb begin
    alu_c = c_q;
    case (alu_op)
      pass_b: alu_y = alu_b;
      add_c: begin
        alu_y = sum[7:0];
        alu_c = sum[8];
      end
      and_op: alu_y = a_q & alu_b;
      or_op:  alu_y = a_q | alu_b;
      eor_op: alu_y = a_q ^ alu_b;
      inc:    alu_y = alu_b + 8'd1;
      default: alu_y = alu_b;
    endcase
  end

  // TAX takes A directly, INX goes through the ALU
  assign x_d = src_sel ? alu_y : a_q;

  // value written back, source of Z and N
  assign wb = (x_load && !src_sel) ? a_q : alu_y;

  always_ff @(posedge ph1 or negedge rst_n) begin
    if (!rst_n) begin
      ir_q <= `OP_NOP;
      a_q  <= '0;
      x_q  <= '0;
      c_q  <= 1'b0;
      z_q  <= 1'b0;
      n_q  <= 1'b0;
      pc_q <= `RESET_PC;
    end else begin
      if (ir_load) ir_q <= rdata;
      if (a_load) a_q <= alu_y;
      if (x_load) x_q <= x_d;
      if (flags_load) begin
        z_q <= (wb == 8'd0);
        n_q <= wb[7];
        // only ADC touches carry
        if (alu_op == add_c) c_q <= alu_c;
      end
      if (pc_load) pc_q <= {th_q, tl_q};
      else if (pc_inc) pc_q <= pc_q + 16'd1;
    end
  end

  always_ff @(posedge ph1) begin
    if (tl_load) tl_q <= rdata;
    if (th_load) th_q <= rdata;
  end

endmodule

// ==== logic/mem_arbiter.sv ====
/*
 * RAM arbiter
 * host port has priority over the CPU, read data is shared by both
 */
`timescale 1ns/1ps
`include "cpu_params.svh"

module mem_arbiter import cpu_pkg::*; (
  input  logic      ph1,
  input  logic      rst_n,
  input  logic      host_req,
  input  logic      host_we,
  input  ram_addr_t host_addr,
  input  data_t     host_wdata,
  input  logic      mem_req,
  input  logic      mem_we,
  input  addr_t     cpu_addr,
  input  data_t     cpu_wdata,
  output logic      cpu_gnt,
  output logic      ram_we,
  output ram_addr_t ram_addr,
  output data_t     ram_wdata
);

  // owner of the previous cycle, i.e. whose data is on rdata now
  logic host_owner_q;

  assign cpu_gnt = ~host_req;

  always_comb begin
    if (host_req) begin
      ram_we    = host_we;
      ram_addr  = host_addr;
      ram_wdata = host_wdata;
    end else begin
      ram_we    = mem_req & mem_we;
      ram_addr  = cpu_addr[`RAM_ADDR_BITS-1:0];
      ram_wdata = cpu_wdata;
    end
  end

  always_ff @(posedge ph1 or negedge rst_n) begin
    if (!rst_n) host_owner_q <= 1'b0;
    else        host_owner_q <= host_req;
  end

endmodule

// ==== logic/ram.sv ====
/*
 * Byte-wide single-port RAM
 * synchronous write, registered read with one cycle latency
 */
`timescale 1ns/1ps
`include "cpu_params.svh"

module ram import cpu_pkg::*; (
  input  logic      ph1,
  input  logic      ram_we,
  input  ram_addr_t ram_addr,
  input  data_t     ram_wdata,
  output data_t     rdata
);

  localparam int ram_depth = 1 << `RAM_ADDR_BITS;

  data_t mem [ram_depth];

  // read returns the old byte on a same-address write
  always_ff @(posedge ph1) begin
    if (ram_we) mem[ram_addr] <= ram_wdata;
    rdata <= mem[ram_addr];
  end

endmodule

// ==== sources.f ====
+incdir+include
logic/cpu_pkg.sv
logic/ram.sv
logic/mem_arbiter.sv
logic/datapath.sv
logic/control.sv
logic/cpu_top.sv
tb/cpu_assert.sv
tb/cpu_tb.sv

// ==== tb/cpu_assert.sv ====
/*
 * Bound checker for the CPU subsystem
 * CPU stall under host ownership, use of read data and sticky halt
 */
`timescale 1ns/1ps

module cpu_assert import cpu_pkg::*; (
  input logic  ph1,
  input logic  rst_n,
  input logic  host_req,
  input logic  mem_req,
  input logic  mem_we,
  input addr_t cpu_addr,
  input logic  host_owner_q,
  input logic  ir_load,
  input logic  tl_load,
  input logic  th_load,
  input logic  a_load,
  input logic  halt
);

  // a blocked CPU request waits unchanged for the grant
  cpu_holds: assert property (@(posedge ph1) disable iff (!rst_n)
    host_req && mem_req |=> mem_req && $stable(mem_we) && $stable(cpu_addr))
    else $error("CPU request changed while the host owned the RAM");

  // rdata from a host read never lands in a CPU register
  host_data: assert property (@(posedge ph1) disable iff (!rst_n)
    host_owner_q |-> !(ir_load || tl_load || th_load || a_load))
    else $error("CPU loaded read data that belonged to the host");

  halt_sticky: assert property (@(posedge ph1) disable iff (!rst_n) halt |=> halt)
    else $error("halt fell without a reset");

endmodule

bind cpu_top cpu_assert chk0 (
  .ph1(ph1), .rst_n(rst_n), .host_req(host_req), .mem_req(mem_req), .mem_we(mem_we),
  .cpu_addr(cpu_addr), .host_owner_q(arb0.host_owner_q), .ir_load(ir_load),
  .tl_load(tl_load), .th_load(th_load), .a_load(a_load), .halt(halt)
);

// ==== tb/cpu_tb.sv ====
/*
 * Testbench for the CPU subsystem
 * runs the command file: host loads, program runs, random host reads, memory checks
 */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

  logic      ph1;
  logic      rst_n;
  logic      run;
  logic      host_req;
  logic      host_we;
  ram_addr_t host_addr;
  data_t     host_wdata;
  data_t     host_rdata;
  logic      halt;

  // programs live below this address, results above it
  localparam ram_addr_t data_base = ram_addr_t'('h80);

  data_t     image [1 << `RAM_ADDR_BITS];
  ram_addr_t prog_addrs [$];
  string     lines [$];
  int        seed = 32'hc2c1_d685;
  int        cycles = 0;
  int        cycle_limit = 0;
  int        errors = 0;
  logic      probe_armed = 1'b0;

  cpu_top dut0 (
    .ph1(ph1), .rst_n(rst_n), .run(run), .host_req(host_req), .host_we(host_we),
    .host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
    .halt(halt)
  );

  initial begin
    ph1 = 1'b0;
    forever #2 ph1 = ~ph1;
  end

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("[FAIL] t=%0t %s", $time, msg);
    abort_run();
  endtask

  always @(posedge ph1) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout, halt never rose within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // hex fields after the command letter
  function automatic void split_hex(input string line, output int vals[$]);
    int start;
    int v;
    vals = {};
    start = 1;
    for (int i = 1; i <= line.len(); i++) begin
      if (i == line.len() || line.getc(i) == " ") begin
        if (i > start && $sscanf(line.substr(start, i - 1), "%h", v) == 1)
          vals.push_back(v);
        start = i + 1;
      end
    end
  endfunction

  task automatic apply_reset();
    @(posedge ph1);
    rst_n <= 1'b0;
    repeat (8) @(posedge ph1);
    rst_n <= 1'b1;
  endtask

  // first value is the start address, one byte per cycle
  task automatic host_write(input int vals[$]);
    ram_addr_t a;
    a = ram_addr_t'(vals[0]);
    for (int i = 1; i < vals.size(); i++) begin
      @(posedge ph1);
      host_req   <= 1'b1;
      host_we    <= 1'b1;
      host_addr  <= a;
      host_wdata <= data_t'(vals[i]);
      image[a] = data_t'(vals[i]);
      if (a < data_base) prog_addrs.push_back(a);
      a = a + ram_addr_t'(1);
    end
    @(posedge ph1);
    host_req <= 1'b0;
    host_we  <= 1'b0;
  endtask

  task automatic host_read(input ram_addr_t addr, output data_t got);
    @(posedge ph1);
    host_req  <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= addr;
    @(posedge ph1);
    host_req <= 1'b0;
    @(negedge ph1);
    got = host_rdata;
  endtask

  task automatic run_program();
    logic      done;
    logic      pending;
    logic      issue;
    ram_addr_t paddr;
    ram_addr_t naddr;
    done    = 1'b0;
    pending = 1'b0;
    naddr   = '0;
    @(posedge ph1);
    run <= 1'b1;
    while (!done || pending) begin
      @(posedge ph1);
      issue = probe_armed && !done && (($random(seed) & 3) == 0);
      if (issue) begin
        naddr = prog_addrs[$unsigned($random(seed)) % prog_addrs.size()];
        host_req  <= 1'b1;
        host_addr <= naddr;
      end else begin
        host_req <= 1'b0;
      end
      @(negedge ph1);
      // read data of last cycle's probe
      if (pending) begin
        assert (host_rdata == image[paddr]) else report_error($sformatf(
          "probe read %02h from %02h, expected %02h", host_rdata, paddr, image[paddr]));
      end
      pending = issue;
      paddr   = naddr;
      done    = halt;
    end
    @(posedge ph1);
    run <= 1'b0;
    probe_armed = 1'b0;
    apply_reset();
  endtask

  initial begin
    int    fd;
    int    runs;
    string line;
    int    vals [$];
    byte   op;
    data_t got;
    rst_n      = 1'b0;
    run        = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    runs       = 0;
    fd = $fopen("tb/test_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the command file tb/test_input.txt");
      abort_run();
    end
    while ($fgets(line, fd)) begin
      lines.push_back(line);
      if (line.len() > 0 && line.getc(0) == "R") runs++;
    end
    $fclose(fd);
    cycle_limit = 200 * runs + 4 * lines.size();
    apply_reset();
    foreach (lines[k]) begin
      line = lines[k];
      op = (line.len() > 0) ? line.getc(0) : "#";
      split_hex(line, vals);
      case (op)
        "L": host_write(vals);
        "C": begin
          host_read(ram_addr_t'(vals[0]), got);
          assert (got == data_t'(vals[1])) else report_error($sformatf(
            "host read %02h from %02h, expected %02h", got, vals[0], vals[1]));
        end
        "P": probe_armed = 1'b1;
        "R": run_program();
        default: ;
      endcase
    end
    if (errors == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// ==== tb/test_input.txt ====
# L addr bytes: host writes bytes from addr up, C addr value: host reads and compares
# R: run until halt then reset, P: random host reads during the next R
L 00 A9 5A 8D 80 00 00
R
C 80 5A
# logic operations
L 00 A9 F0 29 3C 8D 81 00 09 05 8D 82 00
L 0C 49 FF 8D 83 00 00
R
C 81 30
C 82 35
C 83 CA
# add with carry in
L 00 A9 F0 69 20 8D 84 00 69 00 8D 85 00 00
R
C 84 10
C 85 11
# transfer and increment, X wraps to 00
L 00 A9 FE AA E8 E8 E8 8D 86 00 00
R
C 86 FE
# jump over a store, then absolute load
L 87 11
L 90 3C
L 00 4C 08 00 A9 EE 8D 87 00 AD 90 00 8D 88 00 EA 00
R
C 87 11
C 88 3C
# logic program again under random host reads
L 81 00 00 00
L 00 A9 F0 29 3C 8D 81 00 09 05 8D 82 00
L 0C 49 FF 8D 83 00 00
P
R
C 81 30
C 82 35
C 83 CA
